// File: iccm_pkg.sv
`default_nettype none

package iccm_pkg;

   //********************
   // Sizes and address fields
   //********************

   localparam int ICCM_BITS  = 10;
   localparam int NUM_BANKS  = 4;
   localparam int BANK_BITS  = 2;
   localparam int INDEX_BITS = 6;
   localparam int DATA_W     = 32;
   localparam int WORD_W     = 39;
   localparam int NUM_ROWS   = 2;

   // Bank select sits just above the byte-in-word bits
   localparam int BANK_LO  = 2;
   localparam int INDEX_LO = BANK_LO + BANK_BITS;

   //********************
   // Types
   //********************

   typedef logic [ICCM_BITS-1:1]       iccm_addr_t;
   typedef logic [ICCM_BITS-1:BANK_LO] iccm_word_addr_t;
   typedef logic [BANK_BITS-1:0]       bank_sel_t;
   typedef logic [WORD_W-1:0]          bank_word_t;
   typedef bank_word_t [NUM_BANKS-1:0] bank_words_t;
   typedef bank_word_t [NUM_ROWS-1:0]  row_words_t;

   // Even banks use lane lo, odd banks lane hi
   typedef struct packed {
      bank_word_t hi;
      bank_word_t lo;
   } word_pair_t;

   typedef struct packed {
      logic       wren;
      logic       rden;
      logic       is_dword;
      iccm_addr_t addr;
      word_pair_t wr_data;
   } iccm_req_t;

   typedef struct packed {
      logic [2*DATA_W-1:0] rd_data;
      word_pair_t          rd_data_ecc;
   } iccm_rsp_t;

   typedef struct packed {
      logic                  wren;
      logic                  rden;
      logic [INDEX_BITS-1:0] index;
      bank_word_t            wdata;
   } bank_ctrl_t;

   typedef bank_ctrl_t [NUM_BANKS-1:0] bank_ctrl_vec_t;

   // Row hit per bank, outer index is the row
   typedef logic [NUM_ROWS-1:0][NUM_BANKS-1:0] red_sel_t;

   // Halfword address of the second word touched by a request
   function automatic iccm_addr_t incr_addr(input iccm_req_t req);
      logic step;
      step = req.rden | (req.wren & req.is_dword);
      return req.addr + iccm_addr_t'({step, 1'b0});
   endfunction

endpackage

`default_nettype wire

// File: iccm_bank_ram.sv
`default_nettype none

module iccm_bank_ram (
   input  logic                 clk,
   input  iccm_pkg::bank_ctrl_t ctrl,
   output iccm_pkg::bank_word_t rdata
);

   localparam int DEPTH = 1 << iccm_pkg::INDEX_BITS;

   iccm_pkg::bank_word_t mem [0:DEPTH-1];

   // Write port
   always_ff @(posedge clk) begin
      if (ctrl.wren) begin
         mem[ctrl.index] <= ctrl.wdata;
      end
   end

   // Registered read, output holds between reads
   always_ff @(posedge clk) begin
      if (ctrl.rden) begin
         rdata <= mem[ctrl.index];
      end
   end

endmodule

`default_nettype wire

// File: iccm_bank_steer.sv
`default_nettype none

module iccm_bank_steer (
   input  iccm_pkg::iccm_req_t      req,
   output iccm_pkg::bank_ctrl_vec_t bank_ctrl
);

   iccm_pkg::iccm_addr_t             addr_inc;
   logic [iccm_pkg::NUM_BANKS-1:0]   hit_base;
   logic [iccm_pkg::NUM_BANKS-1:0]   hit_inc;

   // Second word for reads and doubleword writes, same word otherwise
   assign addr_inc = iccm_pkg::incr_addr(req);

   //********************
   // Per bank decode
   //********************

   always_comb begin
      for (int i = 0; i < iccm_pkg::NUM_BANKS; i++) begin
         hit_base[i] = (req.addr[iccm_pkg::INDEX_LO-1:iccm_pkg::BANK_LO]
                        == i[iccm_pkg::BANK_BITS-1:0]);
         hit_inc[i]  = (addr_inc[iccm_pkg::INDEX_LO-1:iccm_pkg::BANK_LO]
                        == i[iccm_pkg::BANK_BITS-1:0]);

         bank_ctrl[i].wren = req.wren & (hit_base[i] | hit_inc[i]);
         bank_ctrl[i].rden = req.rden & (hit_base[i] | hit_inc[i]);

         // Base address wins, the incremented one only lands in a different bank
         if (hit_base[i]) begin
            bank_ctrl[i].index = req.addr[iccm_pkg::ICCM_BITS-1:iccm_pkg::INDEX_LO];
         end else begin
            bank_ctrl[i].index = addr_inc[iccm_pkg::ICCM_BITS-1:iccm_pkg::INDEX_LO];
         end

         // Lane by bank parity
         if (i[0]) begin
            bank_ctrl[i].wdata = req.wr_data.hi;
         end else begin
            bank_ctrl[i].wdata = req.wr_data.lo;
         end
      end
   end

endmodule

`default_nettype wire

// File: iccm_redundancy.sv
`default_nettype none

module iccm_redundancy (
   input  logic                  clk,
   input  logic                  rst_n,
   input  iccm_pkg::iccm_req_t   req,
   input  logic                  buf_correct_ecc,
   input  logic                  correction_state,
   output iccm_pkg::red_sel_t    sel_q,
   output iccm_pkg::row_words_t  row_data
);

   iccm_pkg::iccm_addr_t                              addr_inc;
   iccm_pkg::iccm_word_addr_t                         w0;
   iccm_pkg::iccm_word_addr_t                         w1;
   iccm_pkg::iccm_word_addr_t [iccm_pkg::NUM_ROWS-1:0] row_addr;
   logic [iccm_pkg::NUM_ROWS-1:0]                     row_valid;
   logic [iccm_pkg::NUM_ROWS-1:0]                     match;
   logic [iccm_pkg::NUM_ROWS-1:0]                     hit;
   logic [iccm_pkg::NUM_ROWS-1:0]                     fill;
   logic [iccm_pkg::NUM_ROWS-1:0]                     upd;
   iccm_pkg::row_words_t                              data_in;
   iccm_pkg::red_sel_t                                sel;
   logic                                              lru;
   logic                                              lru_en;
   logic                                              lru_in;

   assign addr_inc = iccm_pkg::incr_addr(req);
   assign w0       = req.addr[iccm_pkg::ICCM_BITS-1:iccm_pkg::BANK_LO];
   assign w1       = addr_inc[iccm_pkg::ICCM_BITS-1:iccm_pkg::BANK_LO];

   //********************
   // Address match
   //********************

   always_comb begin
      for (int r = 0; r < iccm_pkg::NUM_ROWS; r++) begin
         // For a word write w1 equals w0
         match[r] = row_valid[r] & ((row_addr[r] == w0) | (row_addr[r] == w1));
         hit[r]   = req.rden & match[r];
         upd[r]   = req.wren & match[r];
         fill[r]  = buf_correct_ecc & (lru == r[0]);

         // Lane picked by the parity of the bank the row belongs to
         if (fill[r] ? w0[iccm_pkg::BANK_LO] : row_addr[r][iccm_pkg::BANK_LO]) begin
            data_in[r] = req.wr_data.hi;
         end else begin
            data_in[r] = req.wr_data.lo;
         end

         for (int i = 0; i < iccm_pkg::NUM_BANKS; i++) begin
            sel[r][i] = hit[r] & (row_addr[r][iccm_pkg::INDEX_LO-1:iccm_pkg::BANK_LO]
                                  == i[iccm_pkg::BANK_BITS-1:0]);
         end
      end
   end

   // Correction toggles, a hit under correction points away from the hit row
   assign lru_en = buf_correct_ecc | (correction_state & (|hit));
   assign lru_in = buf_correct_ecc ? ~lru : ~hit[1];

   //********************
   // Row state
   //********************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         row_valid <= '0;
         lru       <= 1'b0;
         sel_q     <= '0;
      end else begin
         for (int r = 0; r < iccm_pkg::NUM_ROWS; r++) begin
            if (fill[r]) begin
               row_valid[r] <= 1'b1;
            end
         end
         if (lru_en) begin
            lru <= lru_in;
         end
         sel_q <= sel;
      end
   end

   always_ff @(posedge clk) begin
      for (int r = 0; r < iccm_pkg::NUM_ROWS; r++) begin
         if (fill[r]) begin
            row_addr[r] <= w0;
         end
         if (fill[r] | upd[r]) begin
            row_data[r] <= data_in[r];
         end
      end
   end

endmodule

`default_nettype wire

// File: iccm_read_align.sv
`default_nettype none

module iccm_read_align (
   input  logic                  clk,
   input  logic                  rst_n,
   input  iccm_pkg::iccm_req_t   req,
   input  iccm_pkg::bank_words_t bank_rdata,
   input  iccm_pkg::red_sel_t    sel_q,
   input  iccm_pkg::row_words_t  row_data,
   output iccm_pkg::iccm_rsp_t   rsp,
   output logic                  rd_valid
);

   iccm_pkg::iccm_addr_t              addr_inc;
   iccm_pkg::bank_sel_t               b0_q;
   iccm_pkg::bank_sel_t               b1_q;
   logic                              hw_q;
   iccm_pkg::bank_words_t             word_fn;
   iccm_pkg::bank_word_t              w0;
   iccm_pkg::bank_word_t              w1;
   logic [2*iccm_pkg::DATA_W-1:0]     rd_pre;

   assign addr_inc = iccm_pkg::incr_addr(req);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= req.rden;
      end
   end

   // Bank numbers of W0 and W1 plus the halfword bit
   always_ff @(posedge clk) begin
      if (req.rden) begin
         b0_q <= req.addr[iccm_pkg::INDEX_LO-1:iccm_pkg::BANK_LO];
         b1_q <= addr_inc[iccm_pkg::INDEX_LO-1:iccm_pkg::BANK_LO];
         hw_q <= req.addr[1];
      end
   end

   //********************
   // Substitute and align
   //********************

   // Row 1 has priority when both rows cover the same word
   always_comb begin
      for (int i = 0; i < iccm_pkg::NUM_BANKS; i++) begin
         if (sel_q[1][i]) begin
            word_fn[i] = row_data[1];
         end else if (sel_q[0][i]) begin
            word_fn[i] = row_data[0];
         end else begin
            word_fn[i] = bank_rdata[i];
         end
      end
   end

   assign w0     = word_fn[b0_q];
   assign w1     = word_fn[b1_q];
   assign rd_pre = {w1[iccm_pkg::DATA_W-1:0], w0[iccm_pkg::DATA_W-1:0]};

   // Odd halfword shifts zeros into the top 16 bits
   assign rsp.rd_data = hw_q ? {{(iccm_pkg::DATA_W/2){1'b0}},
                                rd_pre[2*iccm_pkg::DATA_W-1:iccm_pkg::DATA_W/2]}
                             : rd_pre;

   assign rsp.rd_data_ecc.hi = w1;
   assign rsp.rd_data_ecc.lo = w0;

endmodule

`default_nettype wire

// File: iccm_mem.sv
`default_nettype none

module iccm_mem (
   input  logic                clk,
   input  logic                rst_n,
   input  iccm_pkg::iccm_req_t req,
   input  logic                buf_correct_ecc,
   input  logic                correction_state,
   output iccm_pkg::iccm_rsp_t rsp,
   output logic                rd_valid
);

   iccm_pkg::bank_ctrl_vec_t bank_ctrl;
   iccm_pkg::bank_words_t    bank_rdata;
   iccm_pkg::red_sel_t       sel_q;
   iccm_pkg::row_words_t     row_data;

   //********************
   // Request steering and banks
   //********************

   iccm_bank_steer u_steer (
      .req       (req),
      .bank_ctrl (bank_ctrl)
   );

   for (genvar i = 0; i < iccm_pkg::NUM_BANKS; i++) begin : g_bank
      iccm_bank_ram u_ram (
         .clk   (clk),
         .ctrl  (bank_ctrl[i]),
         .rdata (bank_rdata[i])
      );
   end

   //********************
   // Redundant rows and read path
   //********************

   iccm_redundancy u_red (
      .clk              (clk),
      .rst_n            (rst_n),
      .req              (req),
      .buf_correct_ecc  (buf_correct_ecc),
      .correction_state (correction_state),
      .sel_q            (sel_q),
      .row_data         (row_data)
   );

   iccm_read_align u_align (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .bank_rdata (bank_rdata),
      .sel_q      (sel_q),
      .row_data   (row_data),
      .rsp        (rsp),
      .rd_valid   (rd_valid)
   );

endmodule

`default_nettype wire

// File: iccm_mem_sva.sv
`default_nettype none

module iccm_mem_sva (
   input logic                clk,
   input logic                rst_n,
   input iccm_pkg::iccm_req_t req,
   input logic                rd_valid
);

   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_count;

   initial begin
      fail_count = 0;
   end

   // Read and write never share a cycle
   a_no_wr_rd : assert property (@(posedge clk) disable iff (!rst_n)
                                 !(req.wren && req.rden))
      else begin
         fail_count = fail_count + 1;
         $error("wren and rden are high in the same cycle");
      end

   a_valid_after_read : assert property (@(posedge clk) disable iff (!rst_n)
                                         req.rden |=> rd_valid)
      else begin
         fail_count = fail_count + 1;
         $error("rd_valid did not follow rden after one cycle");
      end

   a_no_stray_valid : assert property (@(posedge clk) disable iff (!rst_n)
                                       !req.rden |=> !rd_valid)
      else begin
         fail_count = fail_count + 1;
         $error("rd_valid high without a read in the previous cycle");
      end

   a_valid_low_after_reset : assert property (@(posedge clk) !rst_n |=> !rd_valid)
      else begin
         fail_count = fail_count + 1;
         $error("rd_valid high in the cycle after reset");
      end

endmodule

bind iccm_mem iccm_mem_sva u_sva (
   .clk      (clk),
   .rst_n    (rst_n),
   .req      (req),
   .rd_valid (rd_valid)
);

`default_nettype wire

// File: tb_iccm_mem.sv
`default_nettype none

module tb_iccm_mem;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_WORDS  = 1 << (iccm_pkg::ICCM_BITS - 2);
   // Reset, preload of every word pair, then the directed operations
   localparam int TEST_CYCLES   = 3 + NUM_WORDS / 2 + 80;
   localparam int MARGIN_CYCLES = 100;

   logic                clk;
   logic                rst_n;
   iccm_pkg::iccm_req_t req;
   logic                buf_correct_ecc;
   logic                correction_state;
   iccm_pkg::iccm_rsp_t rsp;
   logic                rd_valid;
   integer              seed;

   //********************
   // Reference model state
   //********************

   iccm_pkg::bank_word_t      mem_m [0:NUM_WORDS-1];
   iccm_pkg::iccm_word_addr_t row_addr_m [0:1];
   logic                      row_valid_m [0:1];
   iccm_pkg::bank_word_t      row_data_m [0:1];
   logic                      lru_m;

   iccm_mem u_dut (
      .clk              (clk),
      .rst_n            (rst_n),
      .req              (req),
      .buf_correct_ecc  (buf_correct_ecc),
      .correction_state (correction_state),
      .rsp              (rsp),
      .rd_valid         (rd_valid)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles",
               TEST_CYCLES + MARGIN_CYCLES);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

   //********************
   // Compare tasks
   //********************

   task automatic check_rsp(input string name, input iccm_pkg::iccm_rsp_t got,
                            input iccm_pkg::iccm_rsp_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_valid(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   //********************
   // Model helpers
   //********************

   function automatic iccm_pkg::bank_word_t rand_word();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[iccm_pkg::WORD_W-1:0];
   endfunction

   // Every field depends on the full word address
   function automatic iccm_pkg::bank_word_t fill_word(input iccm_pkg::iccm_word_addr_t wa);
      return {~wa[8:2], wa, ~wa, wa ^ 8'h5a, wa + 8'h33};
   endfunction

   // Odd banks take lane hi
   function automatic iccm_pkg::bank_word_t lane_of(input iccm_pkg::iccm_word_addr_t wa,
                                                    input iccm_pkg::word_pair_t d);
      return wa[2] ? d.hi : d.lo;
   endfunction

   function automatic void model_write(input iccm_pkg::iccm_word_addr_t wa,
                                       input iccm_pkg::word_pair_t d);
      mem_m[wa] = lane_of(wa, d);
      for (int r = 0; r < 2; r++) begin
         if (row_valid_m[r] && row_addr_m[r] == wa) begin
            row_data_m[r] = lane_of(wa, d);
         end
      end
   endfunction

   // Row 1 wins over row 0
   function automatic iccm_pkg::bank_word_t expect_word(input iccm_pkg::iccm_word_addr_t wa);
      if (row_valid_m[1] && row_addr_m[1] == wa) begin
         return row_data_m[1];
      end else if (row_valid_m[0] && row_addr_m[0] == wa) begin
         return row_data_m[0];
      end
      return mem_m[wa];
   endfunction

   function automatic iccm_pkg::iccm_rsp_t expect_rsp(input iccm_pkg::iccm_addr_t addr);
      iccm_pkg::iccm_word_addr_t wa0;
      iccm_pkg::bank_word_t      w0;
      iccm_pkg::bank_word_t      w1;
      logic [95:0]               cat;
      iccm_pkg::iccm_rsp_t       r;
      wa0 = addr[9:2];
      w0  = expect_word(wa0);
      w1  = expect_word(wa0 + 8'd1);
      cat = {16'h0000, w1[31:0], w0[31:0]};
      if (addr[1]) begin
         cat = cat >> 16;
      end
      r.rd_data        = cat[63:0];
      r.rd_data_ecc.hi = w1;
      r.rd_data_ecc.lo = w0;
      return r;
   endfunction

   //********************
   // Bus operations, each one cycle starting on a falling edge
   //********************

   task automatic drive_idle();
      req              = '0;
      buf_correct_ecc  = 1'b0;
      correction_state = 1'b0;
   endtask

   task automatic write_op(input iccm_pkg::iccm_word_addr_t wa, input logic dword,
                           input iccm_pkg::word_pair_t d);
      drive_idle();
      req.wren     = 1'b1;
      req.is_dword = dword;
      req.addr     = {wa, 1'b0};
      req.wr_data  = d;
      model_write(wa, d);
      if (dword) begin
         model_write(wa + 8'd1, d);
      end
      @(negedge clk);
      drive_idle();
   endtask

   // Corrected word in its own lane, noise in the other one
   task automatic correct_op(input iccm_pkg::iccm_word_addr_t wa, input iccm_pkg::bank_word_t w);
      iccm_pkg::word_pair_t d;
      d.lo = rand_word();
      d.hi = rand_word();
      if (wa[2]) begin
         d.hi = w;
      end else begin
         d.lo = w;
      end
      drive_idle();
      buf_correct_ecc = 1'b1;
      req.addr        = {wa, 1'b0};
      req.wr_data     = d;
      row_addr_m[lru_m]  = wa;
      row_valid_m[lru_m] = 1'b1;
      row_data_m[lru_m]  = w;
      lru_m              = ~lru_m;
      @(negedge clk);
      drive_idle();
   endtask

   task automatic read_op(input iccm_pkg::iccm_addr_t addr, input logic corr);
      iccm_pkg::iccm_rsp_t       exp;
      iccm_pkg::iccm_word_addr_t wa0;
      iccm_pkg::iccm_word_addr_t wa1;
      logic                      hit0;
      logic                      hit1;
      wa0  = addr[9:2];
      wa1  = wa0 + 8'd1;
      exp  = expect_rsp(addr);
      hit0 = row_valid_m[0] && (row_addr_m[0] == wa0 || row_addr_m[0] == wa1);
      hit1 = row_valid_m[1] && (row_addr_m[1] == wa0 || row_addr_m[1] == wa1);
      // A hit during correction points the LRU at the other row
      if (corr && (hit0 || hit1)) begin
         lru_m = ~hit1;
      end
      drive_idle();
      req.rden         = 1'b1;
      req.addr         = addr;
      correction_state = corr;
      @(negedge clk);
      check_valid("rd_valid", rd_valid, 1'b1);
      check_rsp("rsp", rsp, exp);
      drive_idle();
   endtask

   //********************
   // Directed tests
   //********************

   task automatic test_reset();
      iccm_pkg::word_pair_t      d;
      iccm_pkg::iccm_word_addr_t wa;
      repeat (2) begin
         @(negedge clk);
         check_valid("rd_valid after reset", rd_valid, 1'b0);
      end
      for (int w = 0; w < NUM_WORDS; w += 2) begin
         wa   = w[7:0];
         d.lo = fill_word(wa);
         d.hi = fill_word(wa + 8'd1);
         write_op(wa, 1'b1, d);
      end
      // No rows valid yet, so every word comes from its bank
      read_op({8'h00, 1'b0}, 1'b0);
      read_op({8'h41, 1'b1}, 1'b0);
      read_op({8'hc2, 1'b0}, 1'b0);
      read_op({8'hff, 1'b1}, 1'b0);
   endtask

   task automatic test_write_read();
      iccm_pkg::word_pair_t d;
      d = {rand_word(), rand_word()};
      write_op(8'h10, 1'b0, d);
      read_op({8'h10, 1'b0}, 1'b0);
      d = {rand_word(), rand_word()};
      write_op(8'h21, 1'b0, d);
      read_op({8'h20, 1'b0}, 1'b0);
      // Doubleword from an odd bank crosses into bank 0
      d = {rand_word(), rand_word()};
      write_op(8'h33, 1'b1, d);
      read_op({8'h33, 1'b0}, 1'b0);
      d = {rand_word(), rand_word()};
      write_op(8'h46, 1'b1, d);
      read_op({8'h46, 1'b0}, 1'b0);
   endtask

   task automatic test_align();
      int          fixed_wa [7] = '{0, 1, 2, 3, 127, 254, 255};
      logic [31:0] r;
      for (int k = 0; k < 7; k++) begin
         read_op({fixed_wa[k][7:0], 1'b0}, 1'b0);
         read_op({fixed_wa[k][7:0], 1'b1}, 1'b0);
      end
      for (int k = 0; k < 6; k++) begin
         r = $random(seed);
         read_op(r[8:0], 1'b0);
      end
   endtask

   task automatic test_correction();
      correct_op(8'h10, rand_word());
      read_op({8'h10, 1'b0}, 1'b0);
      read_op({8'h11, 1'b0}, 1'b0);
      read_op({8'h0f, 1'b1}, 1'b0);
   endtask

   task automatic test_lru();
      correct_op(8'h50, rand_word());
      correct_op(8'h61, rand_word());
      // Third fill evicts the row that took 8'h50
      correct_op(8'h72, rand_word());
      read_op({8'h50, 1'b0}, 1'b0);
      read_op({8'h61, 1'b0}, 1'b0);
      read_op({8'h72, 1'b0}, 1'b0);
      // Hit on row 1 turns the LRU back to row 0
      read_op({8'h72, 1'b0}, 1'b1);
      correct_op(8'h83, rand_word());
      read_op({8'h61, 1'b0}, 1'b0);
      read_op({8'h72, 1'b0}, 1'b0);
      read_op({8'h83, 1'b0}, 1'b0);
   endtask

   task automatic test_row_update();
      iccm_pkg::word_pair_t d;
      // Second word of the doubleword lands on the row holding 8'h72
      d = {rand_word(), rand_word()};
      write_op(8'h71, 1'b1, d);
      read_op({8'h72, 1'b0}, 1'b0);
      read_op({8'h71, 1'b1}, 1'b0);
      d = {rand_word(), rand_word()};
      write_op(8'h83, 1'b0, d);
      read_op({8'h83, 1'b0}, 1'b0);
   endtask

   initial begin
      seed  = 32'h4b06_ec10;
      clk   = 1'b0;
      rst_n = 1'b0;
      drive_idle();
      row_valid_m[0] = 1'b0;
      row_valid_m[1] = 1'b0;
      lru_m          = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      test_reset();
      test_write_read();
      test_align();
      test_correction();
      test_lru();
      test_row_update();
      if (u_dut.u_sva.fail_count != 0) begin
         $display("%0d assertion failures were reported during the run",
                  u_dut.u_sva.fail_count);
         $display("Verification failed");
         $fatal(1, "assertion failures");
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: sources.f
iccm_pkg.sv
iccm_bank_ram.sv
iccm_bank_steer.sv
iccm_redundancy.sv
iccm_read_align.sv
iccm_mem.sv
iccm_mem_sva.sv
tb_iccm_mem.sv

// File: Makefile
.PHONY: all run clean

all: run

obj_dir/Vtb_iccm_mem: sources.f $(wildcard *.sv)
	verilator --binary --timing --assert -f sources.f --top-module tb_iccm_mem

run: obj_dir/Vtb_iccm_mem
	./obj_dir/Vtb_iccm_mem > sim.log 2>&1; cat sim.log
	grep -q "Verification passed" sim.log
	! grep -q "Verification failed" sim.log

clean:
	rm -rf obj_dir sim.log
